// ==== logic/z8_cfg.svh ====
`ifndef Z8_CFG_SVH
`define Z8_CFG_SVH

// Program counter after reset
`define Z8_RESET_PC 16'h000C

// General registers live at 00..7F
`define Z8_REG_COUNT 128

// Special registers in the upper bank
`define Z8_ADDR_FLAGS 8'hFC
`define Z8_ADDR_RP 8'hFD

`endif

// ==== logic/z8IsaPkg.sv ====
`default_nettype none

package z8IsaPkg;

    // Instruction classes by low opcode nibble
    localparam logic [3:0] nibAlu1  = 4'h0;
    localparam logic [3:0] nibAluRr = 4'h2;
    localparam logic [3:0] nibAluIm = 4'h6;
    localparam logic [3:0] nibDjnz  = 4'hA;
    localparam logic [3:0] nibJr    = 4'hB;
    localparam logic [3:0] nibLdIm  = 4'hC;
    localparam logic [3:0] nibJp    = 4'hD;
    localparam logic [3:0] nibMisc  = 4'hF;

    // High nibbles of the single-operand and flag ops
    localparam logic [3:0] hiDec  = 4'h0;
    localparam logic [3:0] hiInc  = 4'h2;
    localparam logic [3:0] hiCom  = 4'h6;
    localparam logic [3:0] hiClr  = 4'hB;
    localparam logic [3:0] hiSwap = 4'hF;
    localparam logic [3:0] hiRcf  = 4'hC;
    localparam logic [3:0] hiScf  = 4'hD;
    localparam logic [3:0] hiCcf  = 4'hE;

    localparam logic [7:0] opSrp = 8'h31;

    // Flag bit positions in the upper nibble of FC
    localparam int flagC = 7;
    localparam int flagZ = 6;
    localparam int flagS = 5;
    localparam int flagV = 4;

    typedef enum logic [3:0] {
        aluAdd, aluAdc, aluSub, aluSbc, aluOr, aluAnd, aluCp, aluXor,
        aluDec, aluInc, aluCom, aluClr, aluSwap, aluPass
    } aluOp_e;

    // Numbered as in the high nibble of jr and jp
    typedef enum logic [3:0] {
        condF, condLt, condLe, condUle, condOv, condMi, condZ, condC,
        condAlways, condGe, condGt, condUgt, condNov, condPl, condNz, condNc
    } cond_e;

    // Second byte as one address or as a dst/src pair of working registers
    typedef union packed {
        logic [7:0]      whole;
        logic [1:0][3:0] nib;
    } operandByte_u;

    function automatic logic [1:0] instrLength(input logic [7:0] op);
        if (op[3:1] == 3'b111) begin
            return 2'd1;
        end
        if (op[3:2] == 2'b01 || op[3:0] == nibJp) begin
            return 2'd3;
        end
        return 2'd2;
    endfunction

endpackage

`default_nettype wire

// ==== logic/z8CorePkg.sv ====
`default_nettype none

package z8CorePkg;

    // What execute does with a decoded instruction
    typedef enum logic [2:0] {
        kindAluWrite,
        kindAluFlagsOnly,
        kindLoad,
        kindDjnz,
        kindJumpRel,
        kindJumpAbs,
        kindFlagOp,
        kindNop
    } opKind_e;

    typedef logic [7:0] regAddr_t;

endpackage

`default_nettype wire

// ==== logic/z8RegFile.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "z8_cfg.svh"

module z8RegFile
    import z8CorePkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  regAddr_t   rdAddrA,
    input  regAddr_t   rdAddrB,
    output logic [7:0] rdDataA,
    output logic [7:0] rdDataB,
    input  logic       wrEn,
    input  regAddr_t   wrAddr,
    input  logic [7:0] wrData,
    input  logic       flagsWrEn,
    input  logic [7:0] flagsNew,
    output logic [7:0] flags,
    output logic [3:0] rp
);
    localparam int idxW = $clog2(`Z8_REG_COUNT);

    logic [7:0] regs [`Z8_REG_COUNT];
    logic [3:0] flagsHi;

    function automatic logic [7:0] readReg(input regAddr_t addr);
        if (int'(addr) < `Z8_REG_COUNT) begin
            return regs[addr[idxW-1:0]];
        end
        case (addr)
            `Z8_ADDR_FLAGS: return {flagsHi, 4'h0};
            `Z8_ADDR_RP:    return {rp, 4'h0};
            default:        return 8'h00;
        endcase
    endfunction

    assign rdDataA = readReg(rdAddrA);
    assign rdDataB = readReg(rdAddrB);
    assign flags   = {flagsHi, 4'h0};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `Z8_REG_COUNT; i++) begin
                regs[i] <= 8'h00;
            end
            flagsHi <= 4'h0;
            rp      <= 4'h0;
        end else begin
            if (wrEn && int'(wrAddr) < `Z8_REG_COUNT) begin
                regs[wrAddr[idxW-1:0]] <= wrData;
            end
            if (wrEn && wrAddr == `Z8_ADDR_RP) begin
                rp <= wrData[7:4];
            end
            // An explicit write to FC beats the ALU flags
            if (wrEn && wrAddr == `Z8_ADDR_FLAGS) begin
                flagsHi <= wrData[7:4];
            end else if (flagsWrEn) begin
                flagsHi <= flagsNew[7:4];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/z8Alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module z8Alu
    import z8IsaPkg::*;
(
    input  aluOp_e     op,
    input  logic [7:0] a,
    input  logic [7:0] b,
    input  logic [7:0] flagsIn,
    output logic [7:0] result,
    output logic [7:0] flagsOut
);
    logic [7:0] arithB;
    logic       carryIn;
    logic       isSub;
    logic [8:0] sum;
    logic       overflow;

    always_comb begin
        arithB  = b;
        carryIn = 1'b0;
        isSub   = 1'b0;
        case (op)
            aluAdc:        carryIn = flagsIn[flagC];
            aluSub, aluCp: isSub   = 1'b1;
            aluSbc: begin
                isSub   = 1'b1;
                carryIn = flagsIn[flagC];
            end
            aluInc:        arithB  = 8'h01;
            aluDec: begin
                arithB = 8'h01;
                isSub  = 1'b1;
            end
            default:       arithB  = b;
        endcase
    end

    // Bit 8 is the carry, or the borrow when subtracting
    assign sum = isSub ? {1'b0, a} - {1'b0, arithB} - {8'h00, carryIn}
                       : {1'b0, a} + {1'b0, arithB} + {8'h00, carryIn};
    assign overflow = (a[7] ^ sum[7]) & (isSub ? (a[7] ^ arithB[7]) : ~(a[7] ^ arithB[7]));

    always_comb begin
        result   = sum[7:0];
        flagsOut = {flagsIn[7:4], 4'h0};
        case (op)
            aluAdd, aluAdc, aluSub, aluSbc, aluCp: begin
                flagsOut[flagC] = sum[8];
                flagsOut[flagV] = overflow;
            end
            aluInc, aluDec: flagsOut[flagV] = overflow;
            aluOr:          result = a | b;
            aluAnd:         result = a & b;
            aluXor:         result = a ^ b;
            aluCom:         result = ~a;
            aluSwap:        result = {a[3:0], a[7:4]};
            aluClr:         result = 8'h00;
            default:        result = b;
        endcase
        if (op inside {aluOr, aluAnd, aluXor, aluCom}) begin
            flagsOut[flagV] = 1'b0;
        end
        // clr and pass leave every flag alone
        if (!(op inside {aluClr, aluPass})) begin
            flagsOut[flagZ] = (result == 8'h00);
            flagsOut[flagS] = result[7];
        end
    end

endmodule

`default_nettype wire

// ==== logic/z8Fetch.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "z8_cfg.svh"

module z8Fetch
    import z8IsaPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    output logic [15:0] fetchAddr,
    output logic        fetchStrobe,
    input  logic [7:0]  fetchData,
    input  logic        redirect,
    input  logic [15:0] nextPc,
    output logic        instrValid,
    output logic [15:0] instrPc,
    output logic [1:0]  instrLen,
    output logic [7:0]  opcode,
    output logic [7:0]  second,
    output logic [7:0]  third
);
    logic [15:0] pcQ;
    logic        bootQ;
    logic        startQ;
    logic        pendQ;
    logic [1:0]  rxIdx;
    logic [1:0]  curLen;
    logic        lastByte;

    // Length comes from the opcode while it is still on the bus
    assign curLen      = (rxIdx == 2'd0) ? instrLength(fetchData) : instrLen;
    assign lastByte    = pendQ && (rxIdx + 2'd1 == curLen);
    assign fetchStrobe = startQ | (pendQ & ~lastByte);
    assign fetchAddr   = pcQ;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcQ        <= `Z8_RESET_PC;
            bootQ      <= 1'b1;
            startQ     <= 1'b0;
            pendQ      <= 1'b0;
            rxIdx      <= 2'd0;
            instrValid <= 1'b0;
        end else begin
            bootQ      <= 1'b0;
            startQ     <= redirect | bootQ;
            pendQ      <= fetchStrobe;
            instrValid <= lastByte;
            if (redirect) begin
                pcQ <= nextPc;
            end else if (fetchStrobe) begin
                pcQ <= pcQ + 16'd1;
            end
            if (pendQ) begin
                rxIdx <= lastByte ? 2'd0 : rxIdx + 2'd1;
            end
        end
    end

    // Assembled instruction
    always_ff @(posedge clk) begin
        if (startQ) begin
            instrPc <= pcQ;
        end
        if (pendQ) begin
            case (rxIdx)
                2'd0: begin
                    opcode   <= fetchData;
                    instrLen <= curLen;
                end
                2'd1:    second <= fetchData;
                default: third  <= fetchData;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/z8Decode.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "z8_cfg.svh"

module z8Decode
    import z8IsaPkg::*;
    import z8CorePkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        instrValid,
    input  logic [15:0] instrPc,
    input  logic [1:0]  instrLen,
    input  logic [7:0]  opcode,
    input  logic [7:0]  second,
    input  logic [7:0]  third,
    input  logic [3:0]  rp,
    output regAddr_t    rdAddrA,
    output regAddr_t    rdAddrB,
    input  logic [7:0]  rdDataA,
    input  logic [7:0]  rdDataB,
    output logic        execValid,
    output opKind_e     kind,
    output aluOp_e      aluOp,
    output cond_e       cond,
    output regAddr_t    dstAddr,
    output logic [7:0]  opA,
    output logic [7:0]  opB,
    output logic [15:0] target,
    output logic [15:0] pc,
    output logic [1:0]  len
);
    operandByte_u operand;
    logic [3:0]   hi;
    logic [3:0]   lo;
    opKind_e      kindD;
    aluOp_e       aluOpD;
    aluOp_e       twoOp;
    logic         twoOpKept;
    logic [7:0]   opBD;
    logic [15:0]  relTarget;

    function automatic regAddr_t working(input logic [3:0] r);
        return {rp, r};
    endfunction

    // Ex addresses name working registers
    function automatic regAddr_t expand(input regAddr_t a);
        return (a[7:4] == 4'hE) ? working(a[3:0]) : a;
    endfunction

    assign operand.whole = second;
    assign hi            = opcode[7:4];
    assign lo            = opcode[3:0];
    assign rdAddrB       = working(operand.nib[0]);
    assign relTarget     = instrPc + {14'd0, instrLen} + {{8{operand.whole[7]}}, operand.whole};

    always_comb begin
        twoOpKept = 1'b1;
        case (hi)
            4'h0:    twoOp = aluAdd;
            4'h1:    twoOp = aluAdc;
            4'h2:    twoOp = aluSub;
            4'h3:    twoOp = aluSbc;
            4'h4:    twoOp = aluOr;
            4'h5:    twoOp = aluAnd;
            4'hA:    twoOp = aluCp;
            4'hB:    twoOp = aluXor;
            default: begin
                twoOp     = aluPass;
                twoOpKept = 1'b0;
            end
        endcase
    end

    always_comb begin
        kindD   = kindNop;
        aluOpD  = aluPass;
        rdAddrA = working(hi);
        case (lo)
            nibAlu1: begin
                rdAddrA = expand(operand.whole);
                kindD   = kindAluWrite;
                case (hi)
                    hiDec:   aluOpD = aluDec;
                    hiInc:   aluOpD = aluInc;
                    hiCom:   aluOpD = aluCom;
                    hiClr:   aluOpD = aluClr;
                    hiSwap:  aluOpD = aluSwap;
                    default: kindD  = kindNop;
                endcase
            end
            nibAluRr, nibAluIm: begin
                rdAddrA = (lo == nibAluRr) ? working(operand.nib[1]) : expand(operand.whole);
                aluOpD  = twoOp;
                if (twoOpKept) begin
                    kindD = (twoOp == aluCp) ? kindAluFlagsOnly : kindAluWrite;
                end
            end
            nibDjnz: begin
                kindD  = kindDjnz;
                aluOpD = aluDec;
            end
            nibJr:   kindD = kindJumpRel;
            nibLdIm: kindD = kindLoad;
            nibJp:   kindD = kindJumpAbs;
            default: begin
                if (opcode == opSrp) begin
                    kindD   = kindLoad;
                    rdAddrA = `Z8_ADDR_RP;
                end else if (lo == nibMisc && hi inside {hiRcf, hiScf, hiCcf}) begin
                    kindD = kindFlagOp;
                end
            end
        endcase
    end

    // Immediate sits in the third byte only for the r,#imm ALU form
    always_comb begin
        case (lo)
            nibAluRr: opBD = rdDataB;
            nibAluIm: opBD = third;
            default:  opBD = operand.whole;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            execValid <= 1'b0;
        end else begin
            execValid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            kind    <= kindD;
            aluOp   <= aluOpD;
            cond    <= cond_e'(hi);
            dstAddr <= rdAddrA;
            opA     <= rdDataA;
            opB     <= opBD;
            target  <= (lo == nibJp) ? {operand.whole, third} : relTarget;
            pc      <= instrPc;
            len     <= instrLen;
        end
    end

endmodule

`default_nettype wire

// ==== logic/z8Execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module z8Execute
    import z8IsaPkg::*;
    import z8CorePkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        execValid,
    input  opKind_e     kind,
    input  aluOp_e      aluOp,
    input  cond_e       cond,
    input  regAddr_t    dstAddr,
    input  logic [7:0]  opA,
    input  logic [7:0]  opB,
    input  logic [15:0] target,
    input  logic [15:0] pc,
    input  logic [1:0]  len,
    input  logic [7:0]  flags,
    output logic        wrEn,
    output regAddr_t    wrAddr,
    output logic [7:0]  wrData,
    output logic        flagsWrEn,
    output logic [7:0]  flagsNew,
    output logic        redirect,
    output logic [15:0] nextPc,
    output logic        retire,
    output logic [15:0] retirePc
);
    logic       firedQ;
    logic       fire;
    logic [7:0] aluResult;
    logic [7:0] aluFlags;
    logic       lt;
    logic       condBase;
    logic       taken;
    logic       newCarry;

    z8Alu alu0 (
        .op(aluOp),
        .a(opA),
        .b(opB),
        .flagsIn(flags),
        .result(aluResult),
        .flagsOut(aluFlags)
    );

    // One retire per decoded instruction
    always_ff @(posedge clk) begin
        if (!rstN) begin
            firedQ <= 1'b0;
        end else begin
            firedQ <= execValid;
        end
    end

    assign fire = execValid & ~firedQ;
    assign lt   = flags[flagS] ^ flags[flagV];

    // Upper eight codes invert the lower eight
    always_comb begin
        case (cond)
            condF, condAlways: condBase = 1'b0;
            condLt, condGe:    condBase = lt;
            condLe, condGt:    condBase = lt | flags[flagZ];
            condUle, condUgt:  condBase = flags[flagC] | flags[flagZ];
            condOv, condNov:   condBase = flags[flagV];
            condMi, condPl:    condBase = flags[flagS];
            condZ, condNz:     condBase = flags[flagZ];
            default:           condBase = flags[flagC];
        endcase
    end

    always_comb begin
        case (kind)
            kindJumpRel, kindJumpAbs: taken = condBase ^ cond[3];
            kindDjnz:                 taken = (aluResult != 8'h00);
            default:                  taken = 1'b0;
        endcase
    end

    // rcf, scf and ccf have high nibbles C, D and E
    assign newCarry = cond[1] ? ~flags[flagC] : cond[0];

    assign wrEn      = fire & (kind inside {kindAluWrite, kindLoad, kindDjnz});
    assign wrAddr    = dstAddr;
    assign wrData    = aluResult;
    assign flagsWrEn = fire & (kind inside {kindAluWrite, kindAluFlagsOnly, kindFlagOp});
    assign flagsNew  = (kind == kindFlagOp) ? {newCarry, flags[flagZ:flagV], 4'h0} : aluFlags;
    assign redirect  = fire;
    assign nextPc    = taken ? target : pc + {14'd0, len};
    assign retire    = fire;
    assign retirePc  = pc;

endmodule

`default_nettype wire

// ==== logic/z8Core.sv ====
`timescale 1ns/100ps
`default_nettype none

module z8Core
    import z8IsaPkg::*;
    import z8CorePkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    output logic [15:0] fetchAddr,
    output logic        fetchStrobe,
    input  logic [7:0]  fetchData,
    output logic        retire,
    output logic [15:0] retirePc,
    output logic        regWrite,
    output regAddr_t    regAddr,
    output logic [7:0]  regData,
    output logic [7:0]  flags
);
    logic        redirect;
    logic [15:0] nextPc;
    logic        instrValid;
    logic [15:0] instrPc;
    logic [1:0]  instrLen;
    logic [7:0]  opcode;
    logic [7:0]  second;
    logic [7:0]  third;
    logic [3:0]  rp;
    regAddr_t    rdAddrA;
    regAddr_t    rdAddrB;
    logic [7:0]  rdDataA;
    logic [7:0]  rdDataB;
    logic        execValid;
    opKind_e     kind;
    aluOp_e      aluOp;
    cond_e       cond;
    regAddr_t    dstAddr;
    logic [7:0]  opA;
    logic [7:0]  opB;
    logic [15:0] target;
    logic [15:0] pc;
    logic [1:0]  len;
    logic        flagsWrEn;
    logic [7:0]  flagsNew;

    z8Fetch fetch0 (
        .clk(clk),
        .rstN(rstN),
        .fetchAddr(fetchAddr),
        .fetchStrobe(fetchStrobe),
        .fetchData(fetchData),
        .redirect(redirect),
        .nextPc(nextPc),
        .instrValid(instrValid),
        .instrPc(instrPc),
        .instrLen(instrLen),
        .opcode(opcode),
        .second(second),
        .third(third)
    );

    z8Decode decode0 (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .instrPc(instrPc),
        .instrLen(instrLen),
        .opcode(opcode),
        .second(second),
        .third(third),
        .rp(rp),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .execValid(execValid),
        .kind(kind),
        .aluOp(aluOp),
        .cond(cond),
        .dstAddr(dstAddr),
        .opA(opA),
        .opB(opB),
        .target(target),
        .pc(pc),
        .len(len)
    );

    // Register file write port doubles as the retire report
    z8Execute execute0 (
        .clk(clk),
        .rstN(rstN),
        .execValid(execValid),
        .kind(kind),
        .aluOp(aluOp),
        .cond(cond),
        .dstAddr(dstAddr),
        .opA(opA),
        .opB(opB),
        .target(target),
        .pc(pc),
        .len(len),
        .flags(flags),
        .wrEn(regWrite),
        .wrAddr(regAddr),
        .wrData(regData),
        .flagsWrEn(flagsWrEn),
        .flagsNew(flagsNew),
        .redirect(redirect),
        .nextPc(nextPc),
        .retire(retire),
        .retirePc(retirePc)
    );

    z8RegFile regFile0 (
        .clk(clk),
        .rstN(rstN),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wrEn(regWrite),
        .wrAddr(regAddr),
        .wrData(regData),
        .flagsWrEn(flagsWrEn),
        .flagsNew(flagsNew),
        .flags(flags),
        .rp(rp)
    );

endmodule

`default_nettype wire

// ==== sim/z8Core_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module z8CoreChecker (
    input logic clk,
    input logic rstN,
    input logic fetchStrobe,
    input logic retire
);
    // Skips the very first edge, before the synchronous reset has taken hold
    logic resetSeen = 1'b0;

    always @(posedge clk) begin
        if (!rstN) begin
            resetSeen <= 1'b1;
        end
    end

    // Only one instruction in flight
    assert property (@(posedge clk) disable iff (!rstN) !(fetchStrobe && retire))
        else $error("fetchStrobe and retire are high in the same cycle");

    assert property (@(posedge clk) (resetSeen && !rstN) |-> (!fetchStrobe && !retire))
        else $error("strobe high while reset is asserted");

    // Shortest instruction is one byte plus three cycles
    assert property (@(posedge clk) disable iff (!rstN) retire |=> !retire [*3])
        else $error("retires closer than four cycles apart");

endmodule

`default_nettype wire

// ==== sim/z8CoreTb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "z8_cfg.svh"

module z8CoreTb ();
    localparam int clkPeriod = 40;
    localparam int resetCycles = 8;
    localparam int maxRetire = 2000;
    localparam int watchdogCycles = resetCycles + maxRetire * 6 + 500;
    localparam logic [31:0] seedValue = 32'h501f_78f6;
    localparam int bitC = 7;
    localparam int bitZ = 6;
    localparam int bitS = 5;
    localparam int bitV = 4;

    logic        clk;
    logic        rstN;
    logic [15:0] fetchAddr;
    logic        fetchStrobe;
    logic [7:0]  fetchData;
    logic        retire;
    logic [15:0] retirePc;
    logic        regWrite;
    logic [7:0]  regAddr;
    logic [7:0]  regData;
    logic [7:0]  flags;

    logic [7:0]  progMem [65536];

    // Reference machine state
    logic [7:0]  mRegs [`Z8_REG_COUNT];
    logic [7:0]  mFlags;
    logic [3:0]  mRp;
    logic [15:0] mPc;

    int          cycle = 0;
    int          startCycle = 0;
    int          lastRetireCycle = -1;
    int          retireCount = 0;
    int          checkCount = 0;
    int          errorCount = 0;
    bit          awaitStart = 1'b1;
    bit          firstSeen = 1'b0;
    logic [15:0] startAddr;
    int unsigned seedDummy;

    z8Core dut0 (
        .clk(clk),
        .rstN(rstN),
        .fetchAddr(fetchAddr),
        .fetchStrobe(fetchStrobe),
        .fetchData(fetchData),
        .retire(retire),
        .retirePc(retirePc),
        .regWrite(regWrite),
        .regAddr(regAddr),
        .regData(regData),
        .flags(flags)
    );

    bind z8Core z8CoreChecker checker0 (
        .clk(clk),
        .rstN(rstN),
        .fetchStrobe(fetchStrobe),
        .retire(retire)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic compareValue(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    function automatic logic [7:0] modelRead(input logic [7:0] addr);
        if (addr < `Z8_REG_COUNT) begin
            return mRegs[addr[6:0]];
        end
        if (addr == `Z8_ADDR_FLAGS) begin
            return mFlags;
        end
        if (addr == `Z8_ADDR_RP) begin
            return {mRp, 4'h0};
        end
        return 8'h00;
    endfunction

    function automatic logic [7:0] workReg(input logic [3:0] r);
        return {mRp, r};
    endfunction

    function automatic logic [7:0] expandAddr(input logic [7:0] a);
        if (a[7:4] == 4'hE) begin
            return workReg(a[3:0]);
        end
        return a;
    endfunction

    function automatic int lengthOf(input logic [7:0] op);
        case (op[3:0])
            4'hE, 4'hF:                     return 1;
            4'h4, 4'h5, 4'h6, 4'h7, 4'hD:   return 3;
            default:                        return 2;
        endcase
    endfunction

    // Codes 8..15 invert the base test of codes 0..7
    function automatic logic condHolds(input logic [3:0] code, input logic [7:0] f);
        logic base;
        case (code[2:0])
            3'd0:    base = 1'b0;
            3'd1:    base = f[bitS] != f[bitV];
            3'd2:    base = (f[bitS] != f[bitV]) || f[bitZ];
            3'd3:    base = f[bitC] || f[bitZ];
            3'd4:    base = f[bitV];
            3'd5:    base = f[bitS];
            3'd6:    base = f[bitZ];
            default: base = f[bitC];
        endcase
        return code[3] ? !base : base;
    endfunction

    task automatic twoOpModel(input logic [3:0] hi, input logic [7:0] a, input logic [7:0] b,
                              output logic [7:0] res, inout logic [7:0] f);
        int  wide;
        logic cin;
        cin = (hi == 4'h1 || hi == 4'h3) ? f[bitC] : 1'b0;
        res = 8'h00;
        case (hi)
            4'h0, 4'h1: begin
                wide    = int'(a) + int'(b) + int'(cin);
                res     = wide[7:0];
                f[bitC] = wide > 255;
                f[bitV] = (a[7] == b[7]) && (res[7] != a[7]);
            end
            4'h2, 4'h3, 4'hA: begin
                wide    = int'(a) - int'(b) - int'(cin);
                res     = wide[7:0];
                f[bitC] = wide < 0;
                f[bitV] = (a[7] != b[7]) && (res[7] != a[7]);
            end
            4'h4: res = a | b;
            4'h5: res = a & b;
            default: res = a ^ b;
        endcase
        if (hi == 4'h4 || hi == 4'h5 || hi == 4'hB) begin
            f[bitV] = 1'b0;
        end
        f[bitZ] = (res == 8'h00);
        f[bitS] = res[7];
    endtask

    // Interprets one instruction at mPc and commits it to the model state
    task automatic stepModel(output int len, output logic expWr, output logic [7:0] expAddr,
                             output logic [7:0] expData);
        logic [7:0]  op;
        logic [7:0]  b2;
        logic [7:0]  b3;
        logic [7:0]  a;
        logic [7:0]  src;
        logic [7:0]  res;
        logic [7:0]  dst;
        logic [7:0]  newFlags;
        logic [3:0]  hi;
        logic        flagWr;
        logic        taken;
        logic [15:0] target;
        op       = progMem[mPc];
        b2       = progMem[mPc + 16'd1];
        b3       = progMem[mPc + 16'd2];
        hi       = op[7:4];
        len      = lengthOf(op);
        expWr    = 1'b0;
        flagWr   = 1'b0;
        taken    = 1'b0;
        res      = 8'h00;
        dst      = 8'h00;
        newFlags = mFlags;
        target   = mPc + 16'd2 + {{8{b2[7]}}, b2};
        case (op[3:0])
            4'h0: begin
                dst    = expandAddr(b2);
                a      = modelRead(dst);
                expWr  = 1'b1;
                flagWr = 1'b1;
                case (hi)
                    4'h0: begin
                        res = a - 8'd1;
                        newFlags[bitV] = (a == 8'h80);
                    end
                    4'h2: begin
                        res = a + 8'd1;
                        newFlags[bitV] = (a == 8'h7F);
                    end
                    4'h6: begin
                        res = ~a;
                        newFlags[bitV] = 1'b0;
                    end
                    4'hB: res = 8'h00;
                    4'hF: res = {a[3:0], a[7:4]};
                    default: begin
                        expWr  = 1'b0;
                        flagWr = 1'b0;
                    end
                endcase
                if (hi != 4'hB) begin
                    newFlags[bitZ] = (res == 8'h00);
                    newFlags[bitS] = res[7];
                end
            end
            4'h2, 4'h6: begin
                if (hi inside {4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hA, 4'hB}) begin
                    if (op[3:0] == 4'h2) begin
                        dst = workReg(b2[7:4]);
                        src = modelRead(workReg(b2[3:0]));
                    end else begin
                        dst = expandAddr(b2);
                        src = b3;
                    end
                    twoOpModel(hi, modelRead(dst), src, res, newFlags);
                    flagWr = 1'b1;
                    expWr  = (hi != 4'hA);
                end
            end
            4'hA: begin
                dst   = workReg(hi);
                res   = modelRead(dst) - 8'd1;
                expWr = 1'b1;
                taken = (res != 8'h00);
            end
            4'hB: taken = condHolds(hi, mFlags);
            4'hC: begin
                dst   = workReg(hi);
                res   = b2;
                expWr = 1'b1;
            end
            4'hD: begin
                taken  = condHolds(hi, mFlags);
                target = {b2, b3};
            end
            4'hF: begin
                if (hi inside {4'hC, 4'hD, 4'hE}) begin
                    flagWr = 1'b1;
                    case (hi)
                        4'hC:    newFlags[bitC] = 1'b0;
                        4'hD:    newFlags[bitC] = 1'b1;
                        default: newFlags[bitC] = !mFlags[bitC];
                    endcase
                end
            end
            default: begin
                // srp
                if (op == 8'h31) begin
                    dst   = `Z8_ADDR_RP;
                    res   = b2;
                    expWr = 1'b1;
                end
            end
        endcase
        expAddr = dst;
        expData = res;
        newFlags[3:0] = 4'h0;
        // Explicit write to FC wins over the flag update
        if (expWr && dst == `Z8_ADDR_FLAGS) begin
            mFlags = {res[7:4], 4'h0};
        end else if (flagWr) begin
            mFlags = newFlags;
        end
        if (expWr && dst < `Z8_REG_COUNT) begin
            mRegs[dst[6:0]] = res;
        end
        if (expWr && dst == `Z8_ADDR_RP) begin
            mRp = res[7:4];
        end
        mPc = taken ? target : mPc + 16'(len);
    endtask

    task automatic checkRetire();
        int         len;
        logic       expWr;
        logic [7:0] expAddr;
        logic [7:0] expData;
        if (awaitStart) begin
            errorCount++;
            $display("Retire at %0t came with no instruction fetch in flight", $time);
        end
        compareValue("fetchAddr of first byte", mPc, startAddr);
        compareValue("retirePc", mPc, retirePc);
        compareValue("flags", {8'h00, mFlags}, {8'h00, flags});
        stepModel(len, expWr, expAddr, expData);
        compareValue("retire cycle offset", 16'(len + 2), 16'(cycle - startCycle));
        compareValue("regWrite", {15'd0, expWr}, {15'd0, regWrite});
        if (expWr) begin
            compareValue("regAddr", {8'h00, expAddr}, {8'h00, regAddr});
            compareValue("regData", {8'h00, expData}, {8'h00, regData});
        end
        retireCount++;
        lastRetireCycle = cycle;
        awaitStart = 1'b1;
    endtask

    // Program memory answers one cycle after the strobe
    always @(posedge clk) begin
        if (fetchStrobe) begin
            fetchData <= progMem[fetchAddr];
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rstN) begin
            if (fetchStrobe && awaitStart) begin
                if (!firstSeen) begin
                    compareValue("first fetchAddr", `Z8_RESET_PC, fetchAddr);
                    firstSeen = 1'b1;
                end
                if (lastRetireCycle >= 0) begin
                    compareValue("fetch start cycle", 16'(lastRetireCycle + 1), 16'(cycle));
                end
                startCycle = cycle;
                startAddr  = fetchAddr;
                awaitStart = 1'b0;
            end
            if (retire) begin
                checkRetire();
            end
        end
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Timeout after %0d retirements, %0d checks, %0d errors",
                 retireCount, checkCount, errorCount);
        $display("Verification failed");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rstN      = 1'b0;
        fetchData = 8'h00;
        seedDummy = $urandom(seedValue);
        for (int i = 0; i < 65536; i++) begin
            progMem[i] = 8'($urandom);
        end
        for (int i = 0; i < `Z8_REG_COUNT; i++) begin
            mRegs[i] = 8'h00;
        end
        mFlags = 8'h00;
        mRp    = 4'h0;
        mPc    = `Z8_RESET_PC;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        wait (retireCount == maxRetire);
        // Flags of the last instruction land one edge later
        @(posedge clk);
        compareValue("final flags", {8'h00, mFlags}, {8'h00, flags});
        $display("Retired %0d instructions, %0d checks, %0d errors",
                 retireCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+logic
logic/z8IsaPkg.sv
logic/z8CorePkg.sv
logic/z8RegFile.sv
logic/z8Alu.sv
logic/z8Fetch.sv
logic/z8Decode.sv
logic/z8Execute.sv
logic/z8Core.sv
sim/z8Core_checker.sv
sim/z8CoreTb.sv

// ==== Bender.yml ====
package:
  name: z8core

sources:
  - include_dirs:
      - logic
    files:
      - logic/z8IsaPkg.sv
      - logic/z8CorePkg.sv
      - logic/z8RegFile.sv
      - logic/z8Alu.sv
      - logic/z8Fetch.sv
      - logic/z8Decode.sv
      - logic/z8Execute.sv
      - logic/z8Core.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/z8Core_checker.sv
      - sim/z8CoreTb.sv
